//--- common/mdu_cfg_pkg.sv
package mdu_cfg_pkg;

    // data path width of the core, every operand and result uses it
    localparam int xlen = 64;

    // W-form operands live in the low half of a register
    localparam int half_xlen = 32;

    // accumulator of both iterative units holds a double-width value
    localparam int acc_w = 2 * xlen;

    // one iteration per operand bit, W forms included
    localparam int iter_count = xlen;

    // counter must reach iter_count itself, so 7 bits for 64
    localparam int cnt_w = 7;

    // The multiplier keeps the product in acc_w bits and the divider keeps
    // the partial remainder and quotient in the same width. Neither unit
    // terminates early, so the latency from start to done is fixed at
    // iter_count plus one cycle for the final sign correction.

    typedef logic [xlen-1:0] xword_t;

    typedef logic [acc_w-1:0] acc_t;

    typedef logic [cnt_w-1:0] cnt_t;

endpackage

//--- common/mdu_op_pkg.sv
package mdu_op_pkg;

    // operations in funct3 order, as they come out of the decoder
    typedef enum logic [3:0] {
        op_mul    = 4'd0,
        op_mulh   = 4'd1,
        op_mulhsu = 4'd2,
        op_mulhu  = 4'd3,
        op_div    = 4'd4,
        op_divu   = 4'd5,
        op_rem    = 4'd6,
        op_remu   = 4'd7
    } mdu_op_e;

    // divides and remainders go to the divider, the rest to the multiplier
    function automatic logic op_is_div(mdu_op_e op);
        return (op == op_div) || (op == op_divu) || (op == op_rem) || (op == op_remu);
    endfunction

    // mul treats a as unsigned since only the low half is returned
    function automatic logic op_a_signed(mdu_op_e op);
        return (op == op_mulh) || (op == op_mulhsu) || (op == op_div) || (op == op_rem);
    endfunction

    // mulhsu is the one operation with mixed signedness
    function automatic logic op_b_signed(mdu_op_e op);
        return (op == op_mulh) || (op == op_div) || (op == op_rem);
    endfunction

    // upper product half for the mulh forms, remainder for rem forms
    function automatic logic op_wants_high(mdu_op_e op);
        logic high;
        high = 1'b0;
        case (op)
            op_mulh, op_mulhsu, op_mulhu: high = 1'b1;
            op_rem, op_remu:              high = 1'b1;
            default:                      high = 1'b0;
        endcase
        return high;
    endfunction

endpackage

//--- divider/mdu_divider.sv
module mdu_divider (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         start,
    input  logic [mdu_cfg_pkg::xlen-1:0] a_in,
    input  logic [mdu_cfg_pkg::xlen-1:0] b_in,
    input  logic                         a_signed,
    input  logic                         b_signed,
    output logic                         done,
    output logic [mdu_cfg_pkg::xlen-1:0] quotient,
    output logic [mdu_cfg_pkg::xlen-1:0] remainder
);
    import mdu_cfg_pkg::*;

    logic             busy;
    cnt_t             count;
    logic             step;
    logic             last;

    // upper half is the partial remainder, lower half the dividend
    // being shifted out while quotient bits are shifted in
    acc_t             acc;
    acc_t             divisor_sh;
    logic             quo_neg;
    logic             rem_neg;
    logic             div_zero;

    logic             a_neg;
    logic             b_neg;
    xword_t           a_mag;
    xword_t           b_mag;

    // one extra bit on the shifted value, the remainder can briefly
    // exceed 2^64 when the divisor is close to all ones
    logic [acc_w:0]   shifted;
    logic [acc_w+1:0] diff;

    xword_t           quo_raw;
    xword_t           rem_raw;

    assign a_neg = a_signed && a_in[xlen-1];
    assign b_neg = b_signed && b_in[xlen-1];
    assign a_mag = a_neg ? -a_in : a_in;
    assign b_mag = b_neg ? -b_in : b_in;

    assign step = busy && !flush && (count != cnt_t'(iter_count));
    assign last = busy && !flush && (count == cnt_t'(iter_count));

    assign shifted = {acc, 1'b0};
    assign diff    = {1'b0, shifted} - {2'b00, divisor_sh};

    assign quo_raw = acc[xlen-1:0];
    assign rem_raw = acc[acc_w-1:xlen];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (flush) begin
                busy <= 1'b0;
            end else if (last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else if (step) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc        <= {{xlen{1'b0}}, a_mag};
            divisor_sh <= {b_mag, {xlen{1'b0}}};
            quo_neg    <= a_neg ^ b_neg;
            rem_neg    <= a_neg;
            div_zero   <= (b_in == '0);
        end else if (step) begin
            // restore by keeping the plain shift when the subtraction borrows
            if (!diff[acc_w+1]) begin
                acc <= {diff[acc_w-1:1], 1'b1};
            end else begin
                acc <= shifted[acc_w-1:0];
            end
        end
    end

    // most negative / -1 falls out of the magnitude path: 2^63 negated is itself
    always_ff @(posedge clk) begin
        if (last) begin
            if (div_zero) begin
                quotient <= '1;
            end else begin
                quotient <= quo_neg ? -quo_raw : quo_raw;
            end
            // a zero divisor leaves |a| here, so the correction restores a
            remainder <= rem_neg ? -rem_raw : rem_raw;
        end
    end

endmodule

//--- dv/mdu_ref_model.svh
`ifndef MDU_REF_MODEL_SVH
`define MDU_REF_MODEL_SVH

// full 128-bit product, each operand extended by its own signedness
function automatic logic [127:0] ref_product(logic [63:0] x, logic [63:0] y, bit xs, bit ys);
    logic [127:0] xe;
    logic [127:0] ye;
    xe = {{64{xs & x[63]}}, x};
    ye = {{64{ys & y[63]}}, y};
    return xe * ye;
endfunction

// M-extension rules: x/0 is all ones with remainder x,
// and the most negative value over -1 is itself with remainder 0
function automatic logic [63:0] ref_div64(logic [63:0] x, logic [63:0] y, bit sgn, bit want_rem);
    logic signed [63:0] sx;
    logic signed [63:0] sy;
    logic [63:0]        res;
    sx = x;
    sy = y;
    if (y == 64'd0) begin
        res = want_rem ? x : {64{1'b1}};
    end else if (sgn && x == {1'b1, 63'd0} && y == {64{1'b1}}) begin
        res = want_rem ? 64'd0 : x;
    end else if (sgn) begin
        res = want_rem ? sx % sy : sx / sy;
    end else begin
        res = want_rem ? x % y : x / y;
    end
    return res;
endfunction

// same rules on 32-bit words for the W forms
function automatic logic [31:0] ref_div32(logic [31:0] x, logic [31:0] y, bit sgn, bit want_rem);
    logic signed [31:0] sx;
    logic signed [31:0] sy;
    logic [31:0]        res;
    sx = x;
    sy = y;
    if (y == 32'd0) begin
        res = want_rem ? x : {32{1'b1}};
    end else if (sgn && x == {1'b1, 31'd0} && y == {32{1'b1}}) begin
        res = want_rem ? 32'd0 : x;
    end else if (sgn) begin
        res = want_rem ? sx % sy : sx / sy;
    end else begin
        res = want_rem ? x % y : x / y;
    end
    return res;
endfunction

// expected result of one request, W results are sign-extended from bit 31
function automatic logic [63:0] ref_result(mdu_op_e o, logic w, logic [63:0] x, logic [63:0] y);
    logic [127:0] p;
    logic [31:0]  r32;
    logic [63:0]  res;
    r32 = 32'd0;
    case (o)
        op_mulh:   p = ref_product(x, y, 1'b1, 1'b1);
        op_mulhsu: p = ref_product(x, y, 1'b1, 1'b0);
        default:   p = ref_product(x, y, 1'b0, 1'b0);
    endcase
    case (o)
        op_mul:                       res = p[63:0];
        op_mulh, op_mulhsu, op_mulhu: res = p[127:64];
        op_div:                       res = ref_div64(x, y, 1'b1, 1'b0);
        op_divu:                      res = ref_div64(x, y, 1'b0, 1'b0);
        op_rem:                       res = ref_div64(x, y, 1'b1, 1'b1);
        default:                      res = ref_div64(x, y, 1'b0, 1'b1);
    endcase
    if (w) begin
        case (o)
            op_mul:  r32 = x[31:0] * y[31:0];
            op_div:  r32 = ref_div32(x[31:0], y[31:0], 1'b1, 1'b0);
            op_divu: r32 = ref_div32(x[31:0], y[31:0], 1'b0, 1'b0);
            op_rem:  r32 = ref_div32(x[31:0], y[31:0], 1'b1, 1'b1);
            default: r32 = ref_div32(x[31:0], y[31:0], 1'b0, 1'b1);
        endcase
        res = {{32{r32[31]}}, r32};
    end
    return res;
endfunction

`endif

//--- dv/tb_mdu.sv
module tb_mdu;
    timeunit 1ns;
    timeprecision 100ps;

    import mdu_cfg_pkg::*;
    import mdu_op_pkg::*;

    `include "mdu_ref_model.svh"

    localparam int clk_period   = 100;
    localparam int resp_lat     = iter_count + 2;
    localparam int n_ops        = 13;
    localparam int n_rand       = 8;
    localparam int n_flush      = 8;
    localparam int n_reqs       = n_ops * 16 + n_ops * n_rand + 2 * n_flush;
    localparam int watch_cycles = n_reqs * 70 + 500;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic    clk = 1'b0;
    logic    rst;
    logic    req_valid;
    logic    req_ready;
    mdu_op_e op;
    logic    word;
    xword_t  a;
    xword_t  b;
    logic    flush;
    logic    resp_valid;
    xword_t  result;

    logic [31:0] lfsr = 32'h24ae;
    int          val_errors = 0;
    int          proto_errors = 0;
    int          cycle = 0;
    int          acc_cycle = 0;
    int          acc_count = 0;
    int          resp_count = 0;
    int          flush_count = 0;
    logic        pending = 1'b0;
    xword_t      exp_result;

    // eight 64-bit ops first, then mulw, divw, divuw, remw, remuw
    mdu_op_e op_tab [n_ops] = '{op_mul, op_mulh, op_mulhsu, op_mulhu, op_div, op_divu,
                                op_rem, op_remu, op_mul, op_div, op_divu, op_rem, op_remu};
    logic [n_ops-1:0] word_tab = 13'b1_1111_0000_0000;
    xword_t      corner64 [4] = '{64'd0, 64'd1, {64{1'b1}}, {1'b1, 63'd0}};
    logic [31:0] corner32 [4] = '{32'd0, 32'd1, {32{1'b1}}, {1'b1, 31'd0}};
    int          flush_delay [4] = '{0, 20, 64, 65};

    mdu_top dut0 (
        .clk, .rst, .req_valid, .req_ready, .op, .word, .a, .b, .flush,
        .resp_valid, .result
    );

    always #(clk_period / 2) clk = ~clk;

    // galois LFSR, one step for every bit handed out
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    // W operands keep random upper bits that the DUT has to ignore
    function automatic xword_t corner_operand(logic w, int idx);
        xword_t r;
        if (w) begin
            r = rand_bits(32) << half_xlen;
            r[31:0] = corner32[idx];
        end else begin
            r = corner64[idx];
        end
        return r;
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        while (!req_ready && n < resp_lat + 10) begin
            @(negedge clk);
            n++;
        end
        assert (req_ready) else begin
            proto_errors++;
            $display("req_ready stayed low for %0d cycles", n);
        end
    endtask

    task automatic send_request(mdu_op_e o, logic w, xword_t x, xword_t y, bit jam);
        wait_ready();
        req_valid = 1'b1;
        op = o;
        word = w;
        a = x;
        b = y;
        @(negedge clk);
        req_valid = 1'b0;
        if (jam) begin
            // a second request while busy must leave the pending one alone
            req_valid = 1'b1;
            a = rand_bits(64);
            b = rand_bits(64);
            repeat (3) @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic flush_during(mdu_op_e o, int delay);
        send_request(o, 1'b0, rand_bits(64), rand_bits(64), 1'b0);
        repeat (delay) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // the sample at an edge shows what the previous edge set, hence one extra cycle
    always @(posedge clk) begin
        if (rst) begin
            pending = 1'b0;
            cycle = 0;
        end else begin
            cycle++;
            if (resp_valid) begin
                resp_count++;
                assert (pending) else begin
                    proto_errors++;
                    $display("resp_valid arrived with no request outstanding");
                end
                assert (cycle - acc_cycle == resp_lat + 1) else begin
                    proto_errors++;
                    $display("response came %0d cycles after acceptance instead of %0d",
                             cycle - acc_cycle - 1, resp_lat);
                end
                assert (result == exp_result) else begin
                    val_errors++;
                    $display("Fail result expected %h received %h", exp_result, result);
                end
                pending = 1'b0;
            end
            if (flush && pending) begin
                pending = 1'b0;
                flush_count++;
            end
            if (req_valid && req_ready) begin
                pending = 1'b1;
                acc_cycle = cycle;
                acc_count++;
                exp_result = ref_result(op, word, a, b);
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid && req_ready)
        else begin
            proto_errors++;
            $display("resp_valid was not a one-cycle pulse followed by req_ready");
        end

    assert property (@(posedge clk) disable iff (rst) req_valid && req_ready |=> !req_ready)
        else begin
            proto_errors++;
            $display("req_ready stayed high after a request was accepted");
        end

    assert property (@(posedge clk) disable iff (rst)
                     flush && !req_ready |=> req_ready && !resp_valid)
        else begin
            proto_errors++;
            $display("flush did not cancel the request and free the unit");
        end

    initial begin
        #(watch_cycles * clk_period);
        $display("watchdog expired after %0d cycles with the test still running", watch_cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        op = op_mul;
        word = 1'b0;
        a = '0;
        b = '0;
        flush = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (req_ready && !resp_valid) else begin
            proto_errors++;
            $display("DUT was not idle after reset");
        end

        // zero, one, minus one and most negative against each other
        for (int k = 0; k < n_ops; k++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    send_request(op_tab[k], word_tab[k], corner_operand(word_tab[k], i),
                                 corner_operand(word_tab[k], j), 1'b0);
                end
            end
        end

        // divisors are shifted down a random amount so quotients spread out
        for (int k = 0; k < n_ops; k++) begin
            for (int i = 0; i < n_rand; i++) begin
                send_request(op_tab[k], word_tab[k], rand_bits(64),
                             rand_bits(64) >> rand_bits(6), i[0]);
            end
        end

        for (int i = 0; i < n_flush; i++) begin
            flush_during(i[0] ? op_divu : op_mulh, flush_delay[i / 2]);
            send_request(op_tab[i], 1'b0, rand_bits(64), rand_bits(64), 1'b0);
        end

        wait_ready();
        @(negedge clk);
        assert (acc_count == resp_count + flush_count) else begin
            proto_errors++;
            $display("%0d requests accepted but %0d answered and %0d flushed",
                     acc_count, resp_count, flush_count);
        end
        $display("errors: %0d value, %0d protocol, over %0d responses and %0d flushes",
                 val_errors, proto_errors, resp_count, flush_count);
        if (val_errors == 0 && proto_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- multiplier/mdu_multiplier.sv
module mdu_multiplier (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         start,
    input  logic [mdu_cfg_pkg::xlen-1:0] a_in,
    input  logic [mdu_cfg_pkg::xlen-1:0] b_in,
    input  logic                         a_signed,
    input  logic                         b_signed,
    output logic                         done,
    output logic [mdu_cfg_pkg::xlen-1:0] prod_lo,
    output logic [mdu_cfg_pkg::xlen-1:0] prod_hi
);
    import mdu_cfg_pkg::*;

    logic          busy;
    cnt_t          count;
    logic          step;
    logic          last;

    // multiplier bits sit in the low half and are consumed from bit 0,
    // partial products build up in the high half
    acc_t          acc;
    xword_t        mcand;
    logic          neg;

    logic          a_neg;
    logic          b_neg;
    xword_t        a_mag;
    xword_t        b_mag;
    logic [xlen:0] sum;
    acc_t          acc_fin;

    assign a_neg = a_signed && a_in[xlen-1];
    assign b_neg = b_signed && b_in[xlen-1];
    assign a_mag = a_neg ? -a_in : a_in;
    assign b_mag = b_neg ? -b_in : b_in;

    assign step = busy && !flush && (count != cnt_t'(iter_count));
    assign last = busy && !flush && (count == cnt_t'(iter_count));

    // carry out of the add goes into the top bit on the shift
    assign sum = {1'b0, acc[acc_w-1:xlen]} + (acc[0] ? {1'b0, mcand} : {(xlen + 1){1'b0}});

    assign acc_fin = neg ? -acc : acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (flush) begin
                busy <= 1'b0;
            end else if (last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else if (step) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= a_mag;
            acc   <= {{xlen{1'b0}}, b_mag};
            neg   <= a_neg ^ b_neg;
        end else if (step) begin
            acc <= {sum, acc[xlen-1:1]};
        end
    end

    // sign is applied once over the full 128-bit product
    always_ff @(posedge clk) begin
        if (last) begin
            prod_lo <= acc_fin[xlen-1:0];
            prod_hi <= acc_fin[acc_w-1:xlen];
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the MDU testbench with Verilator, runs it and checks the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
        -f tb.f --top-module tb_mdu \
    && out="$(./obj_dir/Vtb_mdu)" \
    && printf '%s\n' "$out" \
    && printf '%s\n' "$out" | grep -q "Regression passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb.f
+incdir+dv
common/mdu_cfg_pkg.sv
common/mdu_op_pkg.sv
multiplier/mdu_multiplier.sv
divider/mdu_divider.sv
verilog/mdu_ctrl.sv
verilog/mdu_top.sv
dv/tb_mdu.sv

//--- verilog/mdu_ctrl.sv
module mdu_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  mdu_op_pkg::mdu_op_e          op,
    input  logic                         word,
    input  logic [mdu_cfg_pkg::xlen-1:0] a,
    input  logic [mdu_cfg_pkg::xlen-1:0] b,
    input  logic                         flush,
    output logic                         mul_start,
    output logic                         div_start,
    output logic [mdu_cfg_pkg::xlen-1:0] unit_a,
    output logic [mdu_cfg_pkg::xlen-1:0] unit_b,
    output logic                         a_signed,
    output logic                         b_signed,
    input  logic                         mul_done,
    input  logic [mdu_cfg_pkg::xlen-1:0] prod_lo,
    input  logic [mdu_cfg_pkg::xlen-1:0] prod_hi,
    input  logic                         div_done,
    input  logic [mdu_cfg_pkg::xlen-1:0] quotient,
    input  logic [mdu_cfg_pkg::xlen-1:0] remainder,
    output logic                         resp_valid,
    output logic [mdu_cfg_pkg::xlen-1:0] result
);
    import mdu_cfg_pkg::*;
    import mdu_op_pkg::*;

    localparam int ext_w = xlen - half_xlen;

    logic    busy;
    mdu_op_e op_q;
    logic    word_q;
    logic    accept;
    logic    done_any;
    logic    capture;
    xword_t  pick;
    xword_t  res_fmt;
    logic    a_fill;
    logic    b_fill;

    // only one request in flight, ready is simply the idle state
    assign req_ready = !busy;
    assign accept    = req_valid && !busy;

    assign a_signed = op_a_signed(op);
    assign b_signed = op_b_signed(op);

    assign mul_start = accept && !op_is_div(op);
    assign div_start = accept && op_is_div(op);

    // W forms see only the low word, extended by the op's signedness
    assign a_fill = a_signed && a[half_xlen-1];
    assign b_fill = b_signed && b[half_xlen-1];

    assign unit_a = word ? {{ext_w{a_fill}}, a[half_xlen-1:0]} : a;
    assign unit_b = word ? {{ext_w{b_fill}}, b[half_xlen-1:0]} : b;

    assign done_any = mul_done || div_done;
    assign capture  = busy && done_any && !flush;

    always_comb begin
        if (op_is_div(op_q)) begin
            pick = op_wants_high(op_q) ? remainder : quotient;
        end else begin
            pick = op_wants_high(op_q) ? prod_hi : prod_lo;
        end
    end

    // 32-bit results are always sign-extended, including divuw and remuw
    assign res_fmt = word_q ? {{ext_w{pick[half_xlen-1]}}, pick[half_xlen-1:0]} : pick;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
            end else if (flush) begin
                busy <= 1'b0;
            end else if (capture) begin
                resp_valid <= 1'b1;
            end else if (resp_valid) begin
                // ready comes back one edge after the response pulse
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= op;
            word_q <= word;
        end
        if (capture) begin
            result <= res_fmt;
        end
    end

endmodule

//--- verilog/mdu_top.sv
module mdu_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  mdu_op_pkg::mdu_op_e          op,
    input  logic                         word,
    input  logic [mdu_cfg_pkg::xlen-1:0] a,
    input  logic [mdu_cfg_pkg::xlen-1:0] b,
    input  logic                         flush,
    output logic                         resp_valid,
    output logic [mdu_cfg_pkg::xlen-1:0] result
);
    import mdu_cfg_pkg::*;

    logic   mul_start;
    logic   div_start;
    xword_t unit_a;
    xword_t unit_b;
    logic   a_signed;
    logic   b_signed;
    logic   mul_done;
    xword_t prod_lo;
    xword_t prod_hi;
    logic   div_done;
    xword_t quotient;
    xword_t remainder;

    mdu_ctrl ctrl0 (
        .clk, .rst, .req_valid, .req_ready, .op, .word, .a, .b, .flush,
        .mul_start, .div_start, .unit_a, .unit_b, .a_signed, .b_signed,
        .mul_done, .prod_lo, .prod_hi, .div_done, .quotient, .remainder,
        .resp_valid, .result
    );

    // both units see the flush, only the started one is busy anyway
    mdu_multiplier mul0 (
        .clk, .rst, .flush, .start(mul_start),
        .a_in(unit_a), .b_in(unit_b), .a_signed, .b_signed,
        .done(mul_done), .prod_lo, .prod_hi
    );

    mdu_divider div0 (
        .clk, .rst, .flush, .start(div_start),
        .a_in(unit_a), .b_in(unit_b), .a_signed, .b_signed,
        .done(div_done), .quotient, .remainder
    );

endmodule
